// ==== Bender.yml ====
package:
  name: cache_top

sources:
  - files:
      - verilog/cache_pkg.sv
      - verilog/cache_line.sv
      - verilog/cache_line_array.sv
      - verilog/cache_miss_ctrl.sv
      - verilog/cache_top.sv
  - target: test
    files:
      - verification/avalon_mem_model.sv
      - verification/tb_cache_top.sv

// ==== files.f ====
verilog/cache_pkg.sv
verilog/cache_line.sv
verilog/cache_line_array.sv
verilog/cache_miss_ctrl.sv
verilog/cache_top.sv
verification/avalon_mem_model.sv
verification/tb_cache_top.sv

// ==== verification/avalon_mem_model.sv ====
// Avalon-MM burst memory slave for the cache testbench, with random waitrequest and readdatavalid gaps
`timescale 1ns/1ps

module avalon_mem_model #(
  parameter int               MAX_GAP = 3,
  parameter cache_pkg::word_t FILL    = 32'h0
) (
  input  logic              clk,
  input  logic              rst_n,
  input  cache_pkg::addr_t  address_i,
  input  cache_pkg::burst_t burstcount_i,
  input  logic              read_i,
  input  logic              write_i,
  input  cache_pkg::word_t  writedata_i,
  output cache_pkg::word_t  readdata_o,
  output logic              readdatavalid_o,
  output logic              waitrequest_o,
  input  cache_pkg::addr_t  peek_addr_i,
  output cache_pkg::word_t  peek_data_o,
  output cache_pkg::addr_t  last_wr_addr_o,
  output logic [15:0]       wr_bursts_o
);
  import cache_pkg::*;

  localparam int MEM_WORDS = 2 ** (ADDR_W - 2);

  word_t       mem [MEM_WORDS];
  logic [31:0] rnd_q;
  logic [3:0]  wait_cnt_q;            // consecutive stall cycles
  logic [3:0]  gap_cnt_q;
  logic        wait_q;
  logic        rd_busy_q;
  addr_t       rd_addr_q;
  burst_t      rd_left_q;
  burst_t      wr_beat_q;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = word_t'(i) ^ FILL;     // word address xor fill
    end
  end

  assign waitrequest_o = wait_q || rd_busy_q;
  assign peek_data_o   = mem[peek_addr_i[ADDR_W-1:2]];

  always @(posedge clk) begin
    if (write_i && !waitrequest_o) begin
      mem[address_i[ADDR_W-1:2] + wr_beat_q] <= writedata_i;
    end
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rnd_q           <= 32'd81;
      wait_cnt_q      <= '0;
      gap_cnt_q       <= '0;
      wait_q          <= 1'b0;
      rd_busy_q       <= 1'b0;
      rd_addr_q       <= '0;
      rd_left_q       <= '0;
      wr_beat_q       <= '0;
      readdata_o      <= '0;
      readdatavalid_o <= 1'b0;
      last_wr_addr_o  <= '0;
      wr_bursts_o     <= '0;
    end else begin
      rnd_q <= xorshift(rnd_q);
      if (rnd_q[0] && wait_cnt_q < MAX_GAP) begin
        wait_q     <= 1'b1;
        wait_cnt_q <= wait_cnt_q + 4'd1;
      end else begin
        wait_q     <= 1'b0;
        wait_cnt_q <= '0;
      end
      if (write_i && !waitrequest_o) begin
        if (wr_beat_q == burstcount_i - burst_t'(1)) begin
          wr_beat_q      <= '0;
          wr_bursts_o    <= wr_bursts_o + 16'd1;
          last_wr_addr_o <= address_i;
        end else begin
          wr_beat_q <= wr_beat_q + burst_t'(1);
        end
      end
      readdatavalid_o <= 1'b0;
      if (read_i && !waitrequest_o) begin
        rd_busy_q <= 1'b1;
        rd_addr_q <= address_i;
        rd_left_q <= burstcount_i;
      end else if (rd_busy_q) begin
        if (rnd_q[1] && gap_cnt_q < MAX_GAP) begin
          gap_cnt_q <= gap_cnt_q + 4'd1;  // readdatavalid gap
        end else begin
          gap_cnt_q       <= '0;
          readdatavalid_o <= 1'b1;
          readdata_o      <= mem[rd_addr_q[ADDR_W-1:2]];
          rd_addr_q       <= rd_addr_q + addr_t'(4);
          rd_left_q       <= rd_left_q - burst_t'(1);
          if (rd_left_q == burst_t'(1)) begin
            rd_busy_q <= 1'b0;
          end
        end
      end
    end
  end

endmodule

// ==== verification/tb_cache_top.sv ====
// testbench for cache_top; applies a table of port accesses and checks reads against a shadow memory
`timescale 1ns/1ps

module tb_cache_top;
  import cache_pkg::*;

  localparam int    RESET_CYCLES = 16;
  localparam int    MAX_GAP      = 3;
  localparam int    NUM_ENTRIES  = 20;
  localparam word_t FILL         = 32'h3c5a_a5c3;
  localparam int    TIMEOUT      = NUM_ENTRIES * (2 * LINE_WORDS * (MAX_GAP + 1) + 16)
                                   + RESET_CYCLES + 100;
  localparam logic  RW = 1'b0;
  localparam logic  RO = 1'b1;
  localparam logic  RD = 1'b0;
  localparam logic  WR = 1'b1;

  typedef struct packed {
    logic  ro;
    logic  wr;
    addr_t addr;
    word_t wdata;
    logic  conc;                      // issued together with the next entry
    logic  hit;                       // no master read allowed
    logic  evict;                     // one writeback holding wb_addr
    addr_t wb_addr;
  } entry_t;

  logic   clk = 1'b0;
  logic   rst_n;
  addr_t  rw_address;
  logic   rw_read;
  logic   rw_write;
  word_t  rw_writedata;
  word_t  rw_readdata;
  logic   rw_waitrequest;
  addr_t  ro_address;
  logic   ro_read;
  word_t  ro_readdata;
  logic   ro_waitrequest;
  addr_t  m_address;
  burst_t m_burstcount;
  logic   m_read;
  logic   m_write;
  word_t  m_writedata;
  word_t  m_readdata;
  logic   m_readdatavalid;
  logic   m_waitrequest;
  addr_t  peek_addr;
  word_t  peek_data;
  addr_t  last_wr_addr;
  logic [15:0] wr_bursts;

  entry_t tbl [NUM_ENTRIES];
  word_t  shadow [2 ** (ADDR_W - 2)];
  int     errors;
  int     cycles;
  int     read_cmds;
  int     idx;

  cache_top i_cache_top (
    .clk (clk), .rst_n (rst_n),
    .rw_address_i (rw_address), .rw_read_i (rw_read), .rw_write_i (rw_write),
    .rw_writedata_i (rw_writedata), .rw_readdata_o (rw_readdata),
    .rw_waitrequest_o (rw_waitrequest),
    .ro_address_i (ro_address), .ro_read_i (ro_read), .ro_readdata_o (ro_readdata),
    .ro_waitrequest_o (ro_waitrequest),
    .m_address_o (m_address), .m_burstcount_o (m_burstcount), .m_read_o (m_read),
    .m_write_o (m_write), .m_writedata_o (m_writedata), .m_readdata_i (m_readdata),
    .m_readdatavalid_i (m_readdatavalid), .m_waitrequest_i (m_waitrequest)
  );

  avalon_mem_model #(.MAX_GAP (MAX_GAP), .FILL (FILL)) i_mem_model (
    .clk (clk), .rst_n (rst_n),
    .address_i (m_address), .burstcount_i (m_burstcount), .read_i (m_read),
    .write_i (m_write), .writedata_i (m_writedata), .readdata_o (m_readdata),
    .readdatavalid_o (m_readdatavalid), .waitrequest_o (m_waitrequest),
    .peek_addr_i (peek_addr), .peek_data_o (peek_data),
    .last_wr_addr_o (last_wr_addr), .wr_bursts_o (wr_bursts)
  );

  always #5 clk = ~clk;

  function automatic entry_t table_entry(input logic ro, input logic wr, input addr_t addr,
                                         input word_t wdata, input logic conc, input logic hit,
                                         input logic evict, input addr_t wb_addr);
    return {ro, wr, addr, wdata, conc, hit, evict, wb_addr};
  endfunction

  task automatic drive_request(input entry_t e);
    if (e.ro) begin
      ro_address <= e.addr;
      ro_read    <= 1'b1;
    end else begin
      rw_address   <= e.addr;
      rw_read      <= !e.wr;
      rw_write     <= e.wr;
      rw_writedata <= e.wdata;
    end
    if (e.evict) begin
      peek_addr <= e.wb_addr;
    end
  endtask

  task automatic release_request(input entry_t e);
    if (e.ro) begin
      ro_read <= 1'b0;
    end else begin
      rw_read  <= 1'b0;
      rw_write <= 1'b0;
    end
  endtask

  task automatic check_result(input entry_t e, input int rd_start, input int wb_start);
    word_t got;
    word_t exp;
    exp = shadow[e.addr[ADDR_W-1:2]];
    got = e.ro ? ro_readdata : rw_readdata;
    if (e.wr) begin
      shadow[e.addr[ADDR_W-1:2]] = e.wdata;
    end else begin
      assert (got == exp) else begin
        $display("MISMATCH %s at %h: got %h expected %h",
                 e.ro ? "ro_readdata_o" : "rw_readdata_o", e.addr, got, exp);
        errors++;
      end
    end
    if (e.hit) begin
      assert (read_cmds == rd_start) else begin
        $display("master read seen during a hit access to %h", e.addr);
        errors++;
      end
    end
    if (e.evict) begin
      assert (wr_bursts == 16'(wb_start + 1)) else begin
        $display("expected exactly one writeback burst for the access to %h", e.addr);
        errors++;
      end
      assert (last_wr_addr == {e.wb_addr[ADDR_W-1:OFF_W], {OFF_W{1'b0}}}) else begin
        $display("MISMATCH m_address_o: writeback to %h, expected line of %h",
                 last_wr_addr, e.wb_addr);
        errors++;
      end
      assert (peek_data == shadow[e.wb_addr[ADDR_W-1:2]]) else begin
        $display("MISMATCH m_writedata_o at %h: memory holds %h expected %h",
                 e.wb_addr, peek_data, shadow[e.wb_addr[ADDR_W-1:2]]);
        errors++;
      end
    end
  endtask

  // one entry, or a rw/ro pair issued in the same cycle
  task automatic run_access(input int first, input logic pair);
    entry_t e [2];
    logic   busy [2];
    logic   done [2];
    int     n;
    int     polls;
    int     rd_start;
    int     wb_start;
    n        = pair ? 2 : 1;
    polls    = 0;
    rd_start = read_cmds;
    wb_start = int'(wr_bursts);
    for (int k = 0; k < n; k++) begin
      e[k] = tbl[first + k];
    end
    @(posedge clk);
    for (int k = 0; k < n; k++) begin
      drive_request(e[k]);
      busy[k] = 1'b1;
    end
    busy[1] = pair;
    while (busy[0] || busy[1]) begin
      @(negedge clk);
      for (int k = 0; k < n; k++) begin
        done[k] = busy[k] && !(e[k].ro ? ro_waitrequest : rw_waitrequest);
      end
      for (int k = 0; k < n; k++) begin
        if (done[k]) begin
          if (e[k].hit) begin
            assert (polls == 0) else begin
              $display("hit at %h not answered in the request cycle", e[k].addr);
              errors++;
            end
          end
          if (pair && e[k].ro && polls > 0) begin
            // a waiting ro miss may not finish while the rw miss still waits
            assert (!busy[1 - k] || done[1 - k]) else begin
              $display("read-only miss at %h served ahead of the read/write miss",
                       e[k].addr);
              errors++;
            end
          end
          check_result(e[k], rd_start, wb_start);
          busy[k] = 1'b0;
        end
      end
      polls++;
      @(posedge clk);
      for (int k = 0; k < n; k++) begin
        if (!busy[k]) begin
          release_request(e[k]);
        end
      end
    end
  endtask

  always @(posedge clk) begin
    if (m_read && !m_waitrequest) begin
      read_cmds <= read_cmds + 1;     // accepted read commands
    end
  end

  always @(negedge clk) begin
    if (rst_n === 1'b1 && (m_read || m_write)) begin
      assert (m_burstcount == burst_t'(LINE_WORDS)) else begin
        $display("MISMATCH m_burstcount_o: got %h expected %h", m_burstcount, LINE_WORDS);
        errors++;
      end
      assert (m_address[OFF_W-1:0] == '0) else begin
        $display("MISMATCH m_address_o: %h is not line aligned", m_address);
        errors++;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT) begin
      $display("timeout after %0d cycles with an access still waiting", cycles);
      $display("errors: %0d", errors);
      $display("TESTS FAILED");
      $finish;
    end
  end

  initial begin
    rst_n        = 1'b0;
    rw_address   = '0;
    rw_read      = 1'b0;
    rw_write     = 1'b0;
    rw_writedata = '0;
    ro_address   = '0;
    ro_read      = 1'b0;
    peek_addr    = '0;
    errors       = 0;
    cycles       = 0;
    read_cmds    = 0;
    for (int i = 0; i < 2 ** (ADDR_W - 2); i++) begin
      shadow[i] = word_t'(i) ^ FILL;
    end
    tbl[0]  = table_entry(RW, RD, 16'h0104, 32'h0, 1'b0, 1'b0, 1'b0, 16'h0);
    tbl[1]  = table_entry(RW, RD, 16'h0108, 32'h0, 1'b0, 1'b1, 1'b0, 16'h0);
    tbl[2]  = table_entry(RW, WR, 16'h0108, 32'hdead_beef, 1'b0, 1'b1, 1'b0, 16'h0);
    tbl[3]  = table_entry(RW, RD, 16'h0108, 32'h0, 1'b0, 1'b1, 1'b0, 16'h0);
    tbl[4]  = table_entry(RO, RD, 16'h0108, 32'h0, 1'b0, 1'b1, 1'b0, 16'h0);
    tbl[5]  = table_entry(RW, RD, 16'h1108, 32'h0, 1'b0, 1'b0, 1'b1, 16'h0108);
    tbl[6]  = table_entry(RW, RD, 16'h0108, 32'h0, 1'b0, 1'b0, 1'b0, 16'h0);
    tbl[7]  = table_entry(RW, RD, 16'h0214, 32'h0, 1'b0, 1'b0, 1'b0, 16'h0);
    tbl[8]  = table_entry(RO, RD, 16'h0320, 32'h0, 1'b1, 1'b0, 1'b0, 16'h0);
    tbl[9]  = table_entry(RW, RD, 16'h0218, 32'h0, 1'b0, 1'b0, 1'b0, 16'h0);
    tbl[10] = table_entry(RW, WR, 16'h0230, 32'h1234_5678, 1'b0, 1'b0, 1'b0, 16'h0);
    tbl[11] = table_entry(RW, WR, 16'h0034, 32'hcafe_f00d, 1'b0, 1'b0, 1'b1, 16'h0230);
    tbl[12] = table_entry(RW, RD, 16'h0430, 32'h0, 1'b1, 1'b0, 1'b1, 16'h0034);
    tbl[13] = table_entry(RO, RD, 16'h0524, 32'h0, 1'b0, 1'b0, 1'b0, 16'h0);
    tbl[14] = table_entry(RW, RD, 16'h0034, 32'h0, 1'b0, 1'b0, 1'b0, 16'h0);
    tbl[15] = table_entry(RO, RD, 16'h0230, 32'h0, 1'b0, 1'b0, 1'b0, 16'h0);
    tbl[16] = table_entry(RW, WR, 16'h0524, 32'h0bad_c0de, 1'b1, 1'b1, 1'b0, 16'h0);
    tbl[17] = table_entry(RO, RD, 16'h0528, 32'h0, 1'b0, 1'b1, 1'b0, 16'h0);
    tbl[18] = table_entry(RO, RD, 16'h0524, 32'h0, 1'b0, 1'b1, 1'b0, 16'h0);
    tbl[19] = table_entry(RW, RD, 16'h0524, 32'h0, 1'b0, 1'b1, 1'b0, 16'h0);
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    repeat (4) begin
      @(negedge clk);
      assert (!m_read && !m_write) else begin
        $display("master command raised after reset before any miss");
        errors++;
      end
    end
    idx = 0;
    while (idx < NUM_ENTRIES) begin
      run_access(idx, tbl[idx].conc);
      idx = idx + (tbl[idx].conc ? 2 : 1);
    end
    repeat (4) @(posedge clk);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog/cache_line.sv ====
// one direct-mapped cache line with two tag lookups, one write port and a writeback word read
`timescale 1ns/1ps

module cache_line (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  cache_pkg::addr_t    rw_addr_i,
  input  cache_pkg::addr_t    ro_addr_i,
  input  cache_pkg::line_wr_t wr_i,
  input  logic                wr_sel_i,
  input  cache_pkg::off_t     word_off_i,
  output cache_pkg::line_rd_t rw_rd_o,
  output cache_pkg::line_rd_t ro_rd_o,
  output cache_pkg::word_t    word_o
);
  import cache_pkg::*;

  word_t data_q [LINE_WORDS];
  tag_t  tag_q;
  logic  valid_q;
  logic  dirty_q;

  function automatic line_rd_t lookup(addr_t addr);
    line_rd_t rd;
    rd.hit   = valid_q && (tag_of(addr) == tag_q);
    rd.valid = valid_q;
    rd.dirty = dirty_q;
    rd.tag   = tag_q;
    rd.data  = data_q[wsel_of(off_of(addr))];
    return rd;
  endfunction

  always_comb begin
    rw_rd_o = lookup(rw_addr_i);
    ro_rd_o = lookup(ro_addr_i);
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      dirty_q <= 1'b0;
    end else if (wr_sel_i) begin
      valid_q <= wr_i.valid;
      dirty_q <= wr_i.dirty;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_sel_i) begin
      tag_q                     <= wr_i.tag;
      data_q[wsel_of(wr_i.off)] <= wr_i.data;
    end
  end

  assign word_o = data_q[wsel_of(word_off_i)];  // writeback source

endmodule

// ==== verilog/cache_line_array.sv ====
// all cache lines with per-port line select by index; instantiated once in cache_top
`timescale 1ns/1ps

module cache_line_array (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  cache_pkg::addr_t    rw_addr_i,
  input  cache_pkg::addr_t    ro_addr_i,
  input  cache_pkg::line_wr_t wr_i,
  input  cache_pkg::idx_t     victim_idx_i,
  input  cache_pkg::off_t     victim_off_i,
  output cache_pkg::line_rd_t rw_rd_o,
  output cache_pkg::line_rd_t ro_rd_o,
  output cache_pkg::word_t    victim_word_o
);
  import cache_pkg::*;

  line_rd_t rw_rd [NUM_LINES];
  line_rd_t ro_rd [NUM_LINES];
  word_t    word  [NUM_LINES];

  for (genvar i = 0; i < NUM_LINES; i++) begin : g_line
    cache_line i_line (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .rw_addr_i  (rw_addr_i),
      .ro_addr_i  (ro_addr_i),
      .wr_i       (wr_i),
      .wr_sel_i   (wr_i.en[i]),      // one enable per line
      .word_off_i (victim_off_i),
      .rw_rd_o    (rw_rd[i]),
      .ro_rd_o    (ro_rd[i]),
      .word_o     (word[i])
    );
  end

  // each port only sees the line its index points at
  assign rw_rd_o       = rw_rd[idx_of(rw_addr_i)];
  assign ro_rd_o       = ro_rd[idx_of(ro_addr_i)];
  assign victim_word_o = word[victim_idx_i];

endmodule

// ==== verilog/cache_miss_ctrl.sv ====
// slave handshakes, hit writes and the shared writeback/refill FSM driving the burst master
`timescale 1ns/1ps

module cache_miss_ctrl (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  cache_pkg::addr_t    rw_addr_i,
  input  logic                rw_read_i,
  input  logic                rw_write_i,
  input  cache_pkg::word_t    rw_writedata_i,
  output logic                rw_waitrequest_o,
  input  cache_pkg::addr_t    ro_addr_i,
  input  logic                ro_read_i,
  output logic                ro_waitrequest_o,
  input  cache_pkg::line_rd_t rw_rd_i,
  input  cache_pkg::line_rd_t ro_rd_i,
  input  cache_pkg::word_t    victim_word_i,
  output cache_pkg::idx_t     victim_idx_o,
  output cache_pkg::off_t     victim_off_o,
  output cache_pkg::line_wr_t wr_o,
  output cache_pkg::avm_req_t avm_o,
  input  cache_pkg::word_t    avm_readdata_i,
  input  logic                avm_readdatavalid_i,
  input  logic                avm_waitrequest_i
);
  import cache_pkg::*;

  miss_state_t state_q;
  wsel_t       cnt_q;                 // word within the burst
  addr_t       miss_addr_q;
  addr_t       m_addr_q;
  logic        m_read_q;
  logic        m_write_q;

  logic        rw_miss;
  logic        ro_miss;
  logic        start;
  addr_t       miss_addr;
  line_rd_t    victim;
  logic        last_word;
  logic        direct_wr;
  logic        refill_wr;

  assign rw_miss = (rw_read_i || rw_write_i) && !rw_rd_i.hit;
  assign ro_miss = ro_read_i && !ro_rd_i.hit;

  // a write hit has to wait until the line write port is free again
  assign rw_waitrequest_o = rw_miss || (rw_write_i && state_q != IDLE);
  assign ro_waitrequest_o = ro_miss;

  // ro miss waits a cycle so a landing rw write shows up in the dirty bit
  assign start     = rw_miss || (ro_miss && !rw_write_i);
  assign miss_addr = rw_miss ? rw_addr_i : ro_addr_i;  // rw port first
  assign victim    = rw_miss ? rw_rd_i : ro_rd_i;
  assign last_word = cnt_q == wsel_t'(LINE_WORDS - 1);

  assign direct_wr = state_q == IDLE && rw_write_i && rw_rd_i.hit;
  assign refill_wr = state_q == REFILL && avm_readdatavalid_i;

  assign victim_idx_o = idx_of(miss_addr_q);
  assign victim_off_o = {cnt_q, {BYTE_SEL_W{1'b0}}};

  always_comb begin
    if (state_q == IDLE) begin
      wr_o.en    = line_sel_t'(direct_wr) << idx_of(rw_addr_i);
      wr_o.off   = off_of(rw_addr_i);
      wr_o.tag   = tag_of(rw_addr_i);
      wr_o.valid = 1'b1;
      wr_o.dirty = 1'b1;
      wr_o.data  = rw_writedata_i;
    end else begin
      wr_o.en    = line_sel_t'(refill_wr) << idx_of(miss_addr_q);
      wr_o.off   = victim_off_o;
      wr_o.tag   = tag_of(miss_addr_q);
      wr_o.valid = last_word;         // valid once the last beat lands
      wr_o.dirty = 1'b0;
      wr_o.data  = avm_readdata_i;
    end
  end

  always_comb begin
    avm_o.address    = m_addr_q;
    avm_o.burstcount = burst_t'(LINE_WORDS);
    avm_o.read       = m_read_q;
    avm_o.write      = m_write_q;
    avm_o.writedata  = victim_word_i;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= IDLE;
      cnt_q     <= '0;
      m_addr_q  <= '0;
      m_read_q  <= 1'b0;
      m_write_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          cnt_q <= '0;
          if (start) begin
            if (victim.dirty) begin
              state_q   <= WRITEBACK;
              m_addr_q  <= line_addr(victim.tag, idx_of(miss_addr));
              m_write_q <= 1'b1;
            end else begin
              state_q  <= REFILL;
              m_addr_q <= line_addr(tag_of(miss_addr), idx_of(miss_addr));
              m_read_q <= 1'b1;
            end
          end
        end
        WRITEBACK: begin
          if (!avm_waitrequest_i) begin
            cnt_q <= cnt_q + wsel_t'(1);  // wraps to zero for the refill
            if (last_word) begin
              state_q   <= REFILL;
              m_addr_q  <= line_addr(tag_of(miss_addr_q), idx_of(miss_addr_q));
              m_write_q <= 1'b0;
              m_read_q  <= 1'b1;
            end
          end
        end
        REFILL: begin
          if (m_read_q && !avm_waitrequest_i) begin
            m_read_q <= 1'b0;             // command accepted
          end
          if (avm_readdatavalid_i) begin
            cnt_q <= cnt_q + wsel_t'(1);
            if (last_word) begin
              state_q <= IDLE;
            end
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && start) begin
      miss_addr_q <= miss_addr;
    end
  end

endmodule

// ==== verilog/cache_pkg.sv ====
// cache geometry, shared types and miss FSM states; imported by every cache RTL module
package cache_pkg;

  localparam int ADDR_W     = 16;     // byte address
  localparam int OFF_W      = 4;      // 16-byte lines
  localparam int TAG_W      = 10;
  localparam int IDX_W      = ADDR_W - OFF_W - TAG_W;
  localparam int NUM_LINES  = 2 ** IDX_W;
  localparam int WORD_W     = 32;
  localparam int BYTE_SEL_W = 2;      // bytes within a word
  localparam int WSEL_W     = OFF_W - BYTE_SEL_W;
  localparam int LINE_WORDS = 2 ** WSEL_W;
  localparam int BURST_W    = $clog2(LINE_WORDS + 1);

  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [TAG_W-1:0]     tag_t;
  typedef logic [IDX_W-1:0]     idx_t;
  typedef logic [OFF_W-1:0]     off_t;
  typedef logic [WSEL_W-1:0]    wsel_t;
  typedef logic [WORD_W-1:0]    word_t;
  typedef logic [BURST_W-1:0]   burst_t;
  typedef logic [NUM_LINES-1:0] line_sel_t;

  typedef struct packed {
    line_sel_t en;                    // one-hot line enable
    off_t      off;
    tag_t      tag;
    logic      valid;
    logic      dirty;
    word_t     data;
  } line_wr_t;

  typedef struct packed {
    logic  hit;
    logic  valid;
    logic  dirty;
    tag_t  tag;
    word_t data;                      // word at the port offset
  } line_rd_t;

  typedef struct packed {
    addr_t  address;
    burst_t burstcount;
    logic   read;
    logic   write;
    word_t  writedata;
  } avm_req_t;

  typedef enum logic [1:0] {IDLE, WRITEBACK, REFILL} miss_state_t;

  function automatic tag_t tag_of(addr_t addr);
    return addr[ADDR_W-1 -: TAG_W];
  endfunction

  function automatic idx_t idx_of(addr_t addr);
    return addr[OFF_W +: IDX_W];
  endfunction

  function automatic off_t off_of(addr_t addr);
    return addr[OFF_W-1:0];
  endfunction

  function automatic wsel_t wsel_of(off_t off);
    return off[OFF_W-1 -: WSEL_W];
  endfunction

  // first byte of a line
  function automatic addr_t line_addr(tag_t tag, idx_t idx);
    return {tag, idx, {OFF_W{1'b0}}};
  endfunction

endpackage

// ==== verilog/cache_top.sv ====
// top level of the two-port write-back cache; connects the line array, miss FSM and Avalon ports
`timescale 1ns/1ps

module cache_top (
  input  logic              clk,
  input  logic              rst_n,
  input  cache_pkg::addr_t  rw_address_i,
  input  logic              rw_read_i,
  input  logic              rw_write_i,
  input  cache_pkg::word_t  rw_writedata_i,
  output cache_pkg::word_t  rw_readdata_o,
  output logic              rw_waitrequest_o,
  input  cache_pkg::addr_t  ro_address_i,
  input  logic              ro_read_i,
  output cache_pkg::word_t  ro_readdata_o,
  output logic              ro_waitrequest_o,
  output cache_pkg::addr_t  m_address_o,
  output cache_pkg::burst_t m_burstcount_o,
  output logic              m_read_o,
  output logic              m_write_o,
  output cache_pkg::word_t  m_writedata_o,
  input  cache_pkg::word_t  m_readdata_i,
  input  logic              m_readdatavalid_i,
  input  logic              m_waitrequest_i
);
  import cache_pkg::*;

  line_rd_t rw_rd;
  line_rd_t ro_rd;
  line_wr_t wr;
  word_t    victim_word;
  idx_t     victim_idx;
  off_t     victim_off;
  avm_req_t avm;

  cache_line_array i_line_array (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .rw_addr_i     (rw_address_i),
    .ro_addr_i     (ro_address_i),
    .wr_i          (wr),
    .victim_idx_i  (victim_idx),
    .victim_off_i  (victim_off),
    .rw_rd_o       (rw_rd),
    .ro_rd_o       (ro_rd),
    .victim_word_o (victim_word)
  );

  cache_miss_ctrl i_miss_ctrl (
    .clk_i               (clk),
    .rst_n_i             (rst_n),
    .rw_addr_i           (rw_address_i),
    .rw_read_i           (rw_read_i),
    .rw_write_i          (rw_write_i),
    .rw_writedata_i      (rw_writedata_i),
    .rw_waitrequest_o    (rw_waitrequest_o),
    .ro_addr_i           (ro_address_i),
    .ro_read_i           (ro_read_i),
    .ro_waitrequest_o    (ro_waitrequest_o),
    .rw_rd_i             (rw_rd),
    .ro_rd_i             (ro_rd),
    .victim_word_i       (victim_word),
    .victim_idx_o        (victim_idx),
    .victim_off_o        (victim_off),
    .wr_o                (wr),
    .avm_o               (avm),
    .avm_readdata_i      (m_readdata_i),
    .avm_readdatavalid_i (m_readdatavalid_i),
    .avm_waitrequest_i   (m_waitrequest_i)
  );

  assign rw_readdata_o  = rw_rd.data;   // valid whenever waitrequest is low
  assign ro_readdata_o  = ro_rd.data;

  assign m_address_o    = avm.address;
  assign m_burstcount_o = avm.burstcount;
  assign m_read_o       = avm.read;
  assign m_write_o      = avm.write;
  assign m_writedata_o  = avm.writedata;

endmodule
